//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the crate bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_turf_crate_bridge -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

//--- tb.f
verilog/turf_bridge_pkg.sv
verilog/bridge_dispatch.sv
verilog/link_transactor.sv
verilog/bridge_collect.sv
verilog/turf_crate_bridge.sv
tests/bridge_checker.sv
tests/tb_turf_crate_bridge.sv

//--- tests/bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_checker
    import turf_bridge_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 256
)
(
    input  wire logic                      ps_clk,
    input  wire logic                      rst_n_i,
    input  wire logic                      req_i,
    input  wire logic                      busy_i,
    input  wire logic                      done_i,
    input  wire bridge_done_t              done_data_i,
    input  wire logic [TYPE_W-1:0]         type_i,
    input  wire logic [NUM_LINKS-1:0]      timeout_i,
    input  wire logic [NUM_LINKS-1:0]      invalid_i,
    input  wire logic [NUM_LINKS-1:0]      link_cmd_valid_i,
    input  wire link_cmd_t [NUM_LINKS-1:0] link_cmd_i,
    input  wire logic [NUM_LINKS-1:0]      link_resp_valid_i,
    output int                             err_count_o,
    output int                             done_count_o
);

    localparam int MAX_REQ = 64;

    // Expected values per request line of the trace
    logic [31:0] e_we [MAX_REQ];
    logic [31:0] e_addr [MAX_REQ];
    logic [31:0] e_wdata [MAX_REQ];
    logic [31:0] e_rdata [MAX_REQ];
    logic [31:0] e_status [MAX_REQ];
    logic [31:0] e_tmo [MAX_REQ];
    logic [31:0] e_inv [MAX_REQ];
    logic [31:0] e_type [MAX_REQ];
    int          n_req;
    int          ridx;
    int          cycle;
    int          cmd_cycle;
    int          resp_cycle;
    int          acc_cycle;
    int          cmd_seen;
    logic        exp_busy;
    logic        out_of_reset;

    task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
        err_count_o++;
    endtask

    initial begin
        int fd;
        int rc;
        string line;
        string op;
        string tok;
        err_count_o  = 0;
        done_count_o = 0;
        n_req = 0;
        ridx  = 0;
        cycle = 0;
        cmd_cycle  = 0;
        resp_cycle = 0;
        acc_cycle  = 0;
        cmd_seen   = 0;
        exp_busy     = 1'b0;
        out_of_reset = 1'b0;
        fd = $fopen("tests/bridge_trace.txt", "r");
        if (fd == 0) begin
            $display("Checker could not open the trace file");
            err_count_o++;
        end else begin
            while (!$feof(fd) && n_req < MAX_REQ) begin
                line = "";
                rc = $fgets(line, fd);
                if ($sscanf(line, "%s", op) == 1 && op == "R") begin
                    rc = $sscanf(line, "%s %h %h %h %s %h %h %h %h %h", op, e_we[n_req],
                                 e_addr[n_req], e_wdata[n_req], tok, e_rdata[n_req],
                                 e_status[n_req], e_tmo[n_req], e_inv[n_req], e_type[n_req]);
                    n_req++;
                end
            end
            $fclose(fd);
        end
    end

    //////////////////////////////
    // Command and completion checks
    //////////////////////////////

    // Register and flag values right after reset
    task automatic check_reset_values();
        if (type_i != '0) begin
            value_error("reset bridge type", 64'd0, 64'(type_i));
        end
        if (timeout_i != '0 || invalid_i != '0) begin
            value_error("reset flags", 64'd0, 64'({timeout_i, invalid_i}));
        end
    endtask

    task automatic check_command(input int link);
        string tag;
        tag = $sformatf("req%0d", ridx);
        cmd_seen++;
        cmd_cycle = cycle;
        if (link != int'(e_addr[ridx][CRATE_ADDR_W-1:LINK_ADDR_W])) begin
            value_error({tag, " link"}, 64'(e_addr[ridx][CRATE_ADDR_W-1:LINK_ADDR_W]),
                        64'(link));
        end
        if (cycle - acc_cycle != 1) begin
            value_error({tag, " cycles after request"}, 64'd1, 64'(cycle - acc_cycle));
        end
        if (link_cmd_i[link].we != e_we[ridx][0]) begin
            value_error({tag, " cmd we"}, 64'(e_we[ridx][0]), 64'(link_cmd_i[link].we));
        end
        if (link_cmd_i[link].addr != e_addr[ridx][LINK_ADDR_W-1:0]) begin
            value_error({tag, " cmd addr"}, 64'(e_addr[ridx][LINK_ADDR_W-1:0]),
                        64'(link_cmd_i[link].addr));
        end
        if (link_cmd_i[link].data != e_wdata[ridx]) begin
            value_error({tag, " cmd data"}, 64'(e_wdata[ridx]), 64'(link_cmd_i[link].data));
        end
    endtask

    task automatic check_done();
        string tag;
        logic [31:0] exp_data;
        int exp_cmds;
        tag = $sformatf("req%0d", ridx);
        // Only a good completion carries data
        exp_data = (e_status[ridx] == 32'd0) ? e_rdata[ridx] : 32'd0;
        exp_cmds = (e_status[ridx] == 32'd1) ? 0 : 1;
        if (32'(done_data_i.status) != e_status[ridx]) begin
            value_error({tag, " status"}, 64'(e_status[ridx]), 64'(done_data_i.status));
        end
        if (done_data_i.data != exp_data) begin
            value_error({tag, " data"}, 64'(exp_data), 64'(done_data_i.data));
        end
        if (32'(timeout_i) != e_tmo[ridx]) begin
            value_error({tag, " timeout flags"}, 64'(e_tmo[ridx]), 64'(timeout_i));
        end
        if (32'(invalid_i) != e_inv[ridx]) begin
            value_error({tag, " invalid flags"}, 64'(e_inv[ridx]), 64'(invalid_i));
        end
        if (32'(type_i) != e_type[ridx]) begin
            value_error({tag, " bridge type"}, 64'(e_type[ridx]), 64'(type_i));
        end
        if (cmd_seen != exp_cmds) begin
            value_error({tag, " command count"}, 64'(exp_cmds), 64'(cmd_seen));
        end
        if (e_status[ridx] == 32'd0 && cycle - resp_cycle != 2) begin
            value_error({tag, " cycles after response"}, 64'd2, 64'(cycle - resp_cycle));
        end
        if (e_status[ridx] == 32'd1 && cycle - acc_cycle != 2) begin
            value_error({tag, " cycles after request"}, 64'd2, 64'(cycle - acc_cycle));
        end
        if (e_status[ridx] == 32'd2 && cycle - cmd_cycle < TIMEOUT_CYCLES) begin
            $display("%s timed out only %0d cycles after its command", tag, cycle - cmd_cycle);
            err_count_o++;
        end
        cmd_seen = 0;
        ridx++;
    endtask

    always @(posedge ps_clk) begin
        cycle = cycle + 1;
        if (!rst_n_i) begin
            out_of_reset = 1'b0;
            exp_busy     = 1'b0;
        end else begin
            if (!out_of_reset) begin
                check_reset_values();
                out_of_reset = 1'b1;
            end
            if (busy_i != exp_busy) begin
                value_error($sformatf("req%0d busy", ridx), 64'(exp_busy), 64'(busy_i));
            end
            for (int i = 0; i < NUM_LINKS; i++) begin
                if (link_resp_valid_i[i]) begin
                    resp_cycle = cycle;
                end
                if (link_cmd_valid_i[i]) begin
                    if (ridx >= n_req) begin
                        $display("Command on link %0d with no request pending", i);
                        err_count_o++;
                    end else begin
                        check_command(i);
                    end
                end
            end
            if (done_i) begin
                done_count_o++;
                if (ridx >= n_req) begin
                    $display("Completion seen with no request pending");
                    err_count_o++;
                end else begin
                    check_done();
                end
            end
            // Busy from the cycle after an accepted request to the cycle after done
            if (done_i) begin
                exp_busy = 1'b0;
            end else if (req_i && !exp_busy) begin
                exp_busy  = 1'b1;
                acc_cycle = cycle;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/bridge_trace.txt
# T type | U link_up | C clear
# R we addr wdata delay rdata status tmo inv type poke   (status 0 ok, 1 invalid, 2 timeout)
T 55
U f
R 0 0000010 00000000 3 deadbeef 0 0 0 55 0
R 1 2000044 12345678 5 00000000 0 0 0 55 1
R 0 4000100 00000000 none 00000000 2 4 0 55 0
T 1d
R 0 6000008 00000000 none 00000000 1 4 8 1d 0
R 1 2000010 aaaa5555 none 00000000 1 4 a 1d 0
U d
T 15
R 0 2000020 00000000 none 00000000 1 4 a 15 0
C
R 0 0000abc 00000000 1 cafef00d 0 0 0 15 0
R 1 4001234 87654321 10 00000000 0 0 0 15 1
R 0 6000000 00000000 none 00000000 1 0 8 15 0
T 25
R 0 4000040 00000000 none 00000000 1 0 c 25 0
R 0 1ffffff 00000000 30 0badf00d 0 0 c 25 0

//--- tests/tb_turf_crate_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_turf_crate_bridge
    import turf_bridge_pkg::*;
();

    localparam int TB_TIMEOUT = 40;
    localparam int WAIT_LIMIT = 200;

    logic                             ps_clk;
    logic                             rst_n;
    logic                             req;
    crate_req_t                       req_data;
    logic                             busy;
    logic                             done;
    bridge_done_t                     done_data;
    logic                             type_we;
    logic [TYPE_W-1:0]                type_val;
    logic [TYPE_W-1:0]                type_rd;
    logic [NUM_LINKS-1:0]             link_up;
    logic                             clear;
    logic [NUM_LINKS-1:0]             tmo_flags;
    logic [NUM_LINKS-1:0]             inv_flags;
    logic [NUM_LINKS-1:0]             cmd_valid;
    link_cmd_t [NUM_LINKS-1:0]        cmds;
    logic [NUM_LINKS-1:0]             resp_valid = '0;
    logic [NUM_LINKS-1:0][DATA_W-1:0] resp_data = '0;

    // Link model settings for the request in flight
    int                               model_delay = -1;
    logic [DATA_W-1:0]                model_data = '0;
    int                               model_cnt [NUM_LINKS];

    int                               tb_errors;
    int                               req_count;
    int                               chk_errors;
    int                               chk_dones;

    turf_crate_bridge #(
        .TIMEOUT_CYCLES(TB_TIMEOUT)
    ) turf_crate_bridge_i (
        .ps_clk            (ps_clk),
        .rst_n_i           (rst_n),
        .req_i             (req),
        .req_data_i        (req_data),
        .busy_o            (busy),
        .done_o            (done),
        .done_data_o       (done_data),
        .type_we_i         (type_we),
        .type_i            (type_val),
        .type_o            (type_rd),
        .link_up_i         (link_up),
        .clear_i           (clear),
        .timeout_o         (tmo_flags),
        .invalid_o         (inv_flags),
        .link_cmd_valid_o  (cmd_valid),
        .link_cmd_o        (cmds),
        .link_resp_valid_i (resp_valid),
        .link_resp_data_i  (resp_data)
    );

    bridge_checker #(
        .TIMEOUT_CYCLES(TB_TIMEOUT)
    ) u_checker (
        .ps_clk            (ps_clk),
        .rst_n_i           (rst_n),
        .req_i             (req),
        .busy_i            (busy),
        .done_i            (done),
        .done_data_i       (done_data),
        .type_i            (type_rd),
        .timeout_i         (tmo_flags),
        .invalid_i         (inv_flags),
        .link_cmd_valid_i  (cmd_valid),
        .link_cmd_i        (cmds),
        .link_resp_valid_i (resp_valid),
        .err_count_o       (chk_errors),
        .done_count_o      (chk_dones)
    );

    initial begin
        ps_clk = 1'b0;
        forever #2 ps_clk = ~ps_clk;
    end

    //////////////////////////////
    // Link response models
    //////////////////////////////

    // Answer each command after model_delay cycles
    // A negative delay leaves the link silent
    always @(posedge ps_clk) begin
        for (int i = 0; i < NUM_LINKS; i++) begin
            resp_valid[i] <= 1'b0;
            if (cmd_valid[i] && model_delay > 0) begin
                model_cnt[i] = model_delay;
            end else if (model_cnt[i] > 0) begin
                model_cnt[i] = model_cnt[i] - 1;
                if (model_cnt[i] == 0) begin
                    resp_valid[i] <= 1'b1;
                    resp_data[i]  <= model_data;
                end
            end
        end
    end

    //////////////////////////////
    // Stimulus tasks
    //////////////////////////////

    task automatic write_type(input logic [31:0] val);
        @(posedge ps_clk);
        type_we  <= 1'b1;
        type_val <= val[TYPE_W-1:0];
        @(posedge ps_clk);
        type_we  <= 1'b0;
    endtask

    task automatic pulse_clear();
        @(posedge ps_clk);
        clear <= 1'b1;
        @(posedge ps_clk);
        clear <= 1'b0;
    endtask

    task automatic wait_for_done();
        int cnt;
        cnt = 0;
        while (!done && cnt < WAIT_LIMIT) begin
            @(posedge ps_clk);
            cnt++;
        end
        if (!done) begin
            $display("Request %0d never completed within %0d cycles", req_count, WAIT_LIMIT);
            tb_errors++;
        end
    endtask

    task automatic send_request(input logic we, input logic [31:0] addr,
                                input logic [31:0] wdata, input int delay,
                                input logic [31:0] rdata, input logic poke);
        model_delay = delay;
        model_data  = rdata;
        @(posedge ps_clk);
        req           <= 1'b1;
        req_data.we   <= we;
        req_data.addr <= addr[CRATE_ADDR_W-1:0];
        req_data.data <= wdata;
        if (poke) begin
            // Second strobe to the next link and a type write land while busy
            @(posedge ps_clk);
            req_data.addr[CRATE_ADDR_W-1:LINK_ADDR_W] <= addr[CRATE_ADDR_W-1:LINK_ADDR_W] + 1'b1;
            type_we  <= 1'b1;
            type_val <= 8'hff;
        end
        @(posedge ps_clk);
        req     <= 1'b0;
        type_we <= 1'b0;
        wait_for_done();
        req_count++;
        repeat (3) @(posedge ps_clk);
    endtask

    //////////////////////////////
    // Trace playback
    //////////////////////////////

    initial begin
        int fd;
        int rc;
        int delay;
        string line;
        string op;
        string tok;
        logic [31:0] f [10];
        tb_errors = 0;
        req_count = 0;
        rst_n     = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        type_we   = 1'b0;
        type_val  = '0;
        link_up   = '0;
        clear     = 1'b0;
        for (int i = 0; i < NUM_LINKS; i++) begin
            model_cnt[i] = 0;
        end
        repeat (8) @(posedge ps_clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge ps_clk);
        fd = $fopen("tests/bridge_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tests/bridge_trace.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if ($sscanf(line, "%s", op) != 1 || op.getc(0) == "#") begin
                    continue;
                end
                if (op == "T") begin
                    rc = $sscanf(line, "%s %h", op, f[0]);
                    write_type(f[0]);
                end else if (op == "U") begin
                    rc = $sscanf(line, "%s %h", op, f[0]);
                    @(posedge ps_clk);
                    link_up <= f[0][NUM_LINKS-1:0];
                end else if (op == "C") begin
                    pulse_clear();
                end else if (op == "R") begin
                    rc = $sscanf(line, "%s %h %h %h %s %h %h %h %h %h %h", op, f[0],
                                 f[1], f[2], tok, f[3], f[4], f[5], f[6], f[7], f[8]);
                    if (tok == "none") begin
                        delay = -1;
                    end else begin
                        rc = $sscanf(tok, "%d", delay);
                    end
                    send_request(f[0][0], f[1], f[2], delay, f[3], f[8][0]);
                end else begin
                    $display("Unknown trace operation %s", op);
                    tb_errors++;
                end
            end
            $fclose(fd);
        end
        repeat (5) @(posedge ps_clk);
        if (chk_dones != req_count) begin
            $display("Saw %0d completions for %0d requests", chk_dones, req_count);
            tb_errors++;
        end
        $display("Requests %0d, completions %0d, checker errors %0d, testbench errors %0d",
                 req_count, chk_dones, chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bridge_collect.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_collect
    import turf_bridge_pkg::*;
(
    input  wire logic                            ps_clk,
    input  wire logic                            rst_n_i,

    input  wire logic [NUM_LINKS-1:0]            link_done_i,
    input  wire bridge_done_t [NUM_LINKS-1:0]    link_data_i,

    input  wire logic                            inv_done_i,
    input  wire logic [LINK_SEL_W-1:0]           inv_link_i,

    input  wire logic                            clear_i,

    output logic                                 done_o,
    output bridge_done_t                         done_data_o,
    output logic [NUM_LINKS-1:0]                 timeout_o,
    output logic [NUM_LINKS-1:0]                 invalid_o
);

    logic                             link_any;
    logic [$bits(bridge_done_t)-1:0] link_merge;

    logic                             done_q;
    bridge_done_t                     done_data_q;
    logic [NUM_LINKS-1:0]             timeout_q;
    logic [NUM_LINKS-1:0]             invalid_q;

    //////////////////////////////
    // Completion merge
    //////////////////////////////

    // At most one link completes at a time, so OR is enough
    always_comb begin
        link_any   = 1'b0;
        link_merge = '0;
        for (int i = 0; i < NUM_LINKS; i++) begin
            if (link_done_i[i]) begin
                link_any   = 1'b1;
                link_merge = link_merge | link_data_i[i];
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (inv_done_i) begin
            done_data_q.status <= ERR_INVALID;
            done_data_q.data   <= '0;
        end else if (link_any) begin
            done_data_q <= bridge_done_t'(link_merge);
        end
    end

    //////////////////////////////
    // Done pulse and sticky flags
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            done_q    <= 1'b0;
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            done_q <= link_any | inv_done_i;
            if (clear_i) begin
                timeout_q <= '0;
                invalid_q <= '0;
            end else begin
                for (int i = 0; i < NUM_LINKS; i++) begin
                    if (link_done_i[i] && link_data_i[i].status == ERR_TIMEOUT) begin
                        timeout_q[i] <= 1'b1;
                    end
                end
                if (inv_done_i) begin
                    invalid_q[inv_link_i] <= 1'b1;
                end
            end
        end
    end

    assign done_o      = done_q;
    assign done_data_o = done_data_q;
    assign timeout_o   = timeout_q;
    assign invalid_o   = invalid_q;

endmodule

`default_nettype wire

//--- verilog/bridge_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_dispatch
    import turf_bridge_pkg::*;
(
    input  wire logic                  ps_clk,
    input  wire logic                  rst_n_i,

    input  wire logic                  req_i,
    input  wire crate_req_t            req_data_i,

    input  wire logic                  type_we_i,
    input  wire logic [TYPE_W-1:0]     type_i,
    input  wire logic [NUM_LINKS-1:0]  link_up_i,

    input  wire logic                  done_i,

    output logic [NUM_LINKS-1:0]       start_o,
    output link_cmd_t                  cmd_o,
    output logic                       inv_done_o,
    output logic [LINK_SEL_W-1:0]      inv_link_o,
    output logic                       busy_o,
    output logic [TYPE_W-1:0]          type_o
);

    logic [TYPE_W-1:0]     type_q;
    logic                  busy_q;
    logic                  inv_done_q;
    logic [LINK_SEL_W-1:0] inv_link_q;

    logic                  accept;
    logic [LINK_SEL_W-1:0] link_sel;
    bridge_type_e          link_type;
    logic                  link_ok;

    //////////////////////////////
    // Request decode
    //////////////////////////////

    // New requests only when nothing is in flight
    assign accept   = req_i & ~busy_q;
    assign link_sel = req_data_i.addr[CRATE_ADDR_W-1:LINK_ADDR_W];

    assign link_type = bridge_type_e'(type_q[link_sel*2 +: 2]);

    // Link usable only as an Aurora bridge that is up
    assign link_ok = (link_type == BRIDGE_AURORA) && link_up_i[link_sel];

    always_comb begin
        start_o = '0;
        if (accept && link_ok) begin
            start_o[link_sel] = 1'b1;
        end
    end

    // Forwarded command, transactor captures it on start
    assign cmd_o.we   = req_data_i.we;
    assign cmd_o.addr = req_data_i.addr[LINK_ADDR_W-1:0];
    assign cmd_o.data = req_data_i.data;

    //////////////////////////////
    // Busy and bridge type
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            type_q     <= {NUM_LINKS{BRIDGE_NONE}};
            inv_done_q <= 1'b0;
        end else begin
            if (done_i) begin
                busy_q <= 1'b0;
            end else if (accept) begin
                busy_q <= 1'b1;
            end
            // Type changes wait until the bridge is idle
            if (type_we_i && !busy_q) begin
                type_q <= type_i;
            end
            inv_done_q <= accept & ~link_ok;
        end
    end

    // Which link the rejected request named
    always_ff @(posedge ps_clk) begin
        if (accept) begin
            inv_link_q <= link_sel;
        end
    end

    assign inv_done_o = inv_done_q;
    assign inv_link_o = inv_link_q;
    assign busy_o     = busy_q;
    assign type_o     = type_q;

endmodule

`default_nettype wire

//--- verilog/link_transactor.sv
`timescale 1ns/1ps
`default_nettype none

module link_transactor
    import turf_bridge_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 256
)
(
    input  wire logic              ps_clk,
    input  wire logic              rst_n_i,

    input  wire logic              start_i,
    input  wire link_cmd_t         cmd_i,

    input  wire logic              resp_valid_i,
    input  wire logic [DATA_W-1:0] resp_data_i,

    output logic                   cmd_valid_o,
    output link_cmd_t              cmd_o,

    output logic                   done_o,
    output bridge_done_t           done_data_o
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    typedef enum logic {
        IDLE      = 1'b0,
        WAIT_RESP = 1'b1
    } xact_state_e;

    xact_state_e  state_q;
    logic [CNT_W-1:0] wait_cnt_q;
    logic         expired;

    logic         cmd_valid_q;
    link_cmd_t    cmd_q;
    logic         done_q;
    bridge_done_t done_data_q;

    // Last waiting cycle before giving up
    assign expired = (wait_cnt_q == CNT_W'(TIMEOUT_CYCLES - 1));

    //////////////////////////////
    // Command and response FSM
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            wait_cnt_q  <= '0;
            cmd_valid_q <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            cmd_valid_q <= 1'b0;
            done_q      <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        cmd_valid_q <= 1'b1;
                        wait_cnt_q  <= '0;
                        state_q     <= WAIT_RESP;
                    end
                end
                WAIT_RESP: begin
                    // A response wins over an expiry in the same cycle
                    if (resp_valid_i || expired) begin
                        done_q  <= 1'b1;
                        state_q <= IDLE;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Payload capture
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (state_q == IDLE && start_i) begin
            cmd_q <= cmd_i;
        end
        if (state_q == WAIT_RESP) begin
            if (resp_valid_i) begin
                done_data_q.status <= ERR_OK;
                done_data_q.data   <= resp_data_i;
            end else if (expired) begin
                // No data on a timeout
                done_data_q.status <= ERR_TIMEOUT;
                done_data_q.data   <= '0;
            end
        end
    end

    assign cmd_valid_o = cmd_valid_q;
    assign cmd_o       = cmd_q;
    assign done_o      = done_q;
    assign done_data_o = done_data_q;

endmodule

`default_nettype wire

//--- verilog/turf_bridge_pkg.sv
`default_nettype none

package turf_bridge_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    // TURFIO links behind the crate bridge
    localparam int NUM_LINKS = 4;

    // Full crate address, top bits pick the link
    localparam int CRATE_ADDR_W = 27;

    // Address as seen by one link
    localparam int LINK_ADDR_W = 25;

    // Link select bits taken off the crate address
    localparam int LINK_SEL_W = CRATE_ADDR_W - LINK_ADDR_W;

    // Two bits of bridge type per link
    localparam int TYPE_W = 2 * NUM_LINKS;

    localparam int DATA_W = 32;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_e;

    // Completion status
    typedef enum logic [1:0] {
        ERR_OK      = 2'd0,
        ERR_INVALID = 2'd1,
        ERR_TIMEOUT = 2'd2
    } bridge_err_e;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    // Request from the register side, 60 bits
    typedef struct packed {
        logic                    we;
        logic [CRATE_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]       data;
    } crate_req_t;

    // Command to one link, select bits stripped
    typedef struct packed {
        logic                   we;
        logic [LINK_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      data;
    } link_cmd_t;

    // Completion with status and read data
    typedef struct packed {
        bridge_err_e       status;
        logic [DATA_W-1:0] data;
    } bridge_done_t;

endpackage

`default_nettype wire

//--- verilog/turf_crate_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module turf_crate_bridge
    import turf_bridge_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 256
)
(
    input  wire logic                                   ps_clk,
    input  wire logic                                   rst_n_i,

    input  wire logic                                   req_i,
    input  wire crate_req_t                             req_data_i,
    output logic                                        busy_o,
    output logic                                        done_o,
    output bridge_done_t                                done_data_o,

    input  wire logic                                   type_we_i,
    input  wire logic [TYPE_W-1:0]                      type_i,
    output logic [TYPE_W-1:0]                           type_o,
    input  wire logic [NUM_LINKS-1:0]                   link_up_i,

    input  wire logic                                   clear_i,
    output logic [NUM_LINKS-1:0]                        timeout_o,
    output logic [NUM_LINKS-1:0]                        invalid_o,

    output logic [NUM_LINKS-1:0]                        link_cmd_valid_o,
    output link_cmd_t [NUM_LINKS-1:0]                   link_cmd_o,
    input  wire logic [NUM_LINKS-1:0]                   link_resp_valid_i,
    input  wire logic [NUM_LINKS-1:0][DATA_W-1:0]       link_resp_data_i
);

    logic [NUM_LINKS-1:0]          start;
    link_cmd_t                     cmd;
    logic                          inv_done;
    logic [LINK_SEL_W-1:0]         inv_link;
    logic [NUM_LINKS-1:0]          link_done;
    bridge_done_t [NUM_LINKS-1:0]  link_data;

    //////////////////////////////
    // Dispatch
    //////////////////////////////

    bridge_dispatch u_dispatch (
        .ps_clk     (ps_clk),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .req_data_i (req_data_i),
        .type_we_i  (type_we_i),
        .type_i     (type_i),
        .link_up_i  (link_up_i),
        .done_i     (done_o),
        .start_o    (start),
        .cmd_o      (cmd),
        .inv_done_o (inv_done),
        .inv_link_o (inv_link),
        .busy_o     (busy_o),
        .type_o     (type_o)
    );

    // One transactor per TURFIO link
    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
        link_transactor #(
            .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
        ) u_xact (
            .ps_clk       (ps_clk),
            .rst_n_i      (rst_n_i),
            .start_i      (start[i]),
            .cmd_i        (cmd),
            .resp_valid_i (link_resp_valid_i[i]),
            .resp_data_i  (link_resp_data_i[i]),
            .cmd_valid_o  (link_cmd_valid_o[i]),
            .cmd_o        (link_cmd_o[i]),
            .done_o       (link_done[i]),
            .done_data_o  (link_data[i])
        );
    end

    bridge_collect u_collect (
        .ps_clk      (ps_clk),
        .rst_n_i     (rst_n_i),
        .link_done_i (link_done),
        .link_data_i (link_data),
        .inv_done_i  (inv_done),
        .inv_link_i  (inv_link),
        .clear_i     (clear_i),
        .done_o      (done_o),
        .done_data_o (done_data_o),
        .timeout_o   (timeout_o),
        .invalid_o   (invalid_o)
    );

endmodule

`default_nettype wire
